// File: opl.f
+incdir+verif
common/axis_pkg.sv
common/opl_pkg.sv
rtl/stream_fifo.sv
lookup/header_decode.sv
lookup/port_select.sv
stats/stats_counters.sv
rtl/opl_top.sv
verif/tb_opl.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
# Pass or fail comes from the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_opl -f opl.f -o vtb_opl \
  || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/vtb_opl)
echo "$out"

echo "$out" | grep -qx "Test passed" \
  && echo "Simulation run succeeded" \
  || { echo "Simulation run did not succeed"; exit 1; }

// File: verif/tb_opl_checks.svh
//##########################################################
// Reference rules and concurrent checks for tb_opl
// Included inside the tb_opl module body
// Data checks fire on output transfers only
//##########################################################
`ifndef TB_OPL_CHECKS_SVH
`define TB_OPL_CHECKS_SVH

  // Egress port for a one-hot source port
  function automatic axis_pkg::port_t port_rule(input axis_pkg::port_t src);
    logic cpu;
    cpu = src[1] | src[3] | src[5] | src[7];  // Odd bits are DMA ports
    if (src == 8'h00) return 8'h01;
    if (cpu) return src >> 1;
    return src << 1;
  endfunction

  // Register after n events, flag once the count has wrapped
  function automatic logic [31:0] count_reg_value(input int unsigned n);
    logic [31:0] r;
    r                  = '0;
    r[31]              = (n >= (1 << COUNT_WIDTH));
    r[COUNT_WIDTH-1:0] = COUNT_WIDTH'(n % (1 << COUNT_WIDTH));
    return r;
  endfunction

  // Expected stats from the traffic since the last clear
  function automatic opl_pkg::stats_t traffic_stats(input logic [31:0] last);
    opl_pkg::stats_t s;
    s.pkt_in       = count_reg_value(pkt_cnt);
    s.pkt_out      = count_reg_value(pkt_cnt);   // Everything drained
    s.icmp_out     = count_reg_value(icmp_cnt);
    s.tgt_out      = count_reg_value(tgt_cnt);
    s.tgt_out_last = last;
    return s;
  endfunction

  a_beat_expected: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    m_axis_tvalid |-> exp_pending)
    else stop_with_error("An output beat appeared while no beat was expected");

  // Ready follows the number of queued beats
  a_tready: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    s_axis_tready == exp_ready)
    else report_mismatch("s_axis_tready", $sampled(exp_ready), $sampled(s_axis_tready));

  a_tdata: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    out_fire |-> m_axis_tdata == exp_front.tdata)
    else report_mismatch("tdata", $sampled(exp_front.tdata), $sampled(m_axis_tdata));

  a_tkeep: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    out_fire |-> m_axis_tkeep == exp_front.tkeep)
    else report_mismatch("tkeep", $sampled(exp_front.tkeep), $sampled(m_axis_tkeep));

  a_tlast: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    out_fire |-> m_axis_tlast == exp_front.tlast)
    else report_mismatch("tlast", $sampled(exp_front.tlast), $sampled(m_axis_tlast));

  // Rewritten dst_port on head beats, input tuser otherwise
  a_tuser: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    out_fire |-> m_axis_tuser == exp_front.tuser)
    else report_mismatch("tuser", $sampled(exp_front.tuser), $sampled(m_axis_tuser));

  property p_stat(logic [31:0] act, logic [31:0] exp);
    @(posedge axis_aclk) disable iff (!axis_resetn) chk_stats |-> act == exp;
  endproperty

  a_pkt_in: assert property (p_stat(stats.pkt_in, exp_stats.pkt_in))
    else report_mismatch("pkt_in", $sampled(exp_stats.pkt_in), $sampled(stats.pkt_in));
  a_pkt_out: assert property (p_stat(stats.pkt_out, exp_stats.pkt_out))
    else report_mismatch("pkt_out", $sampled(exp_stats.pkt_out), $sampled(stats.pkt_out));
  a_icmp_out: assert property (p_stat(stats.icmp_out, exp_stats.icmp_out))
    else report_mismatch("icmp_out", $sampled(exp_stats.icmp_out), $sampled(stats.icmp_out));
  a_tgt_out: assert property (p_stat(stats.tgt_out, exp_stats.tgt_out))
    else report_mismatch("tgt_out", $sampled(exp_stats.tgt_out), $sampled(stats.tgt_out));
  a_tgt_last: assert property (p_stat(stats.tgt_out_last, exp_stats.tgt_out_last))
    else report_mismatch("tgt_out_last", $sampled(exp_stats.tgt_out_last),
                         $sampled(stats.tgt_out_last));

`endif

// File: verif/tb_opl.sv
//##########################################################
// Testbench for the output port lookup stage
// COUNT_WIDTH is 4 so the overflow flags are reachable
// All checks are concurrent assertions in tb_opl_checks.svh
//##########################################################
`timescale 1ns/1ps

module tb_opl;

  localparam int          COUNT_WIDTH = 4;
  localparam int          FIRST_PKTS  = 10;  // Stays below the wrap
  localparam int          SECOND_PKTS = 20;  // Wraps the packet counters
  localparam int          TOTAL_PKTS  = FIRST_PKTS + SECOND_PKTS;
  localparam logic [31:0] TGT_A       = 32'hC0A8_0107;
  localparam logic [31:0] TGT_B       = 32'h0A00_0042;
  localparam int          FIFO_DEPTH_BITS = 2;
  localparam int          READY_LIMIT = (1 << FIFO_DEPTH_BITS) - 1;  // Depth minus one

  logic                             axis_aclk;
  logic                             axis_resetn;
  logic [axis_pkg::DATA_WIDTH-1:0]  s_axis_tdata;
  logic [axis_pkg::KEEP_WIDTH-1:0]  s_axis_tkeep;
  logic [axis_pkg::TUSER_WIDTH-1:0] s_axis_tuser;
  logic                             s_axis_tvalid;
  logic                             s_axis_tready;
  logic                             s_axis_tlast;
  logic [axis_pkg::DATA_WIDTH-1:0]  m_axis_tdata;
  logic [axis_pkg::KEEP_WIDTH-1:0]  m_axis_tkeep;
  logic [axis_pkg::TUSER_WIDTH-1:0] m_axis_tuser;
  logic                             m_axis_tvalid;
  logic                             m_axis_tready;
  logic                             m_axis_tlast;
  logic [31:0]                      tgt_ip;
  logic                             clear_counters;
  opl_pkg::stats_t                  stats;

  axis_pkg::beat_t stim_in[$];   // Beats still to send
  axis_pkg::beat_t stim_out[$];  // Matching expected output beats
  axis_pkg::beat_t exp_q[$];     // Accepted and not yet seen at the output
  axis_pkg::beat_t exp_front;
  logic            exp_pending;
  logic            exp_ready;    // Input ready expected from queued beats
  logic            out_fire;
  logic            chk_stats;    // Arms the stats assertions for one edge
  opl_pkg::stats_t exp_stats;
  logic [31:0]     lcg_state;
  int unsigned     pkt_cnt;      // Since the last clear
  int unsigned     icmp_cnt;
  int unsigned     tgt_cnt;

  initial axis_aclk = 1'b0;
  always #5 axis_aclk = ~axis_aclk;  // 10 ns period

  opl_top #(.FIFO_DEPTH_BITS(FIFO_DEPTH_BITS), .COUNT_WIDTH(COUNT_WIDTH)) dut0 (.*);

  assign out_fire = m_axis_tvalid & m_axis_tready;

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string name, input logic [511:0] exp,
                                 input logic [511:0] act);
    stop_with_error($sformatf("Mismatch %s expected %0h actual %0h", name, exp, act));
  endtask

  `include "tb_opl_checks.svh"

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    return (next_rand() >> 16) % n;  // Upper bits, low ones cycle fast
  endfunction

  // Random packets of 1 to 4 beats with their expected output
  task automatic build_packets(input int unsigned n_pkts);
    axis_pkg::beat_t beat;
    axis_pkg::port_t src;
    int unsigned     len;
    int unsigned     sel;
    logic [7:0]      proto;
    logic [31:0]     dip;
    for (int unsigned p = 0; p < n_pkts; p++) begin
      len   = 1 + pick(4);
      sel   = pick(9);
      src   = (sel == 8) ? 8'h00 : 8'(1 << sel);  // Zero, MAC or DMA source
      sel   = pick(3);
      proto = (sel == 0) ? 8'd1 : ((sel == 1) ? 8'd6 : 8'd17);
      dip   = pick(2) ? tgt_ip : next_rand();
      pkt_cnt++;
      if (proto == 8'd1) icmp_cnt++;
      if (dip == tgt_ip) tgt_cnt++;
      for (int unsigned b = 0; b < len; b++) begin
        for (int w = 0; w < 16; w++) beat.tdata[w*32 +: 32] = next_rand();
        for (int w = 0; w < 4; w++) beat.tuser[w*32 +: 32] = next_rand();
        beat.tkeep          = (b == len - 1) ? {next_rand(), next_rand()} : '1;
        beat.tuser.src_port = src;
        beat.tuser.pkt_len  = 16'(len * 64);
        beat.tlast          = (b == len - 1);
        if (b == 0) begin
          beat.tdata[191:184] = proto;  // IPv4 protocol
          beat.tdata[271:240] = dip;    // IPv4 destination
        end
        stim_in.push_back(beat);
        if (b == 0) beat.tuser.dst_port = port_rule(src);
        stim_out.push_back(beat);
      end
    end
  endtask

  // Cycle loop, runs until every beat has left the DUT
  task automatic run_traffic(input int unsigned n_pkts);
    logic in_fire;
    logic out_fire_q;
    build_packets(n_pkts);
    in_fire    = 1'b0;
    out_fire_q = 1'b0;
    while (stim_in.size() != 0 || exp_q.size() != 0) begin
      @(posedge axis_aclk);
      #1;
      if (out_fire_q) void'(exp_q.pop_front());
      if (in_fire) begin
        void'(stim_in.pop_front());
        exp_q.push_back(stim_out.pop_front());
      end
      s_axis_tvalid = (stim_in.size() != 0);
      if (s_axis_tvalid) begin
        s_axis_tdata = stim_in[0].tdata;
        s_axis_tkeep = stim_in[0].tkeep;
        s_axis_tuser = stim_in[0].tuser;
        s_axis_tlast = stim_in[0].tlast;
      end
      m_axis_tready = (pick(4) != 0);  // Random back-pressure
      exp_pending   = (exp_q.size() != 0);
      exp_ready     = (exp_q.size() < READY_LIMIT);
      exp_front     = exp_pending ? exp_q[0] : '0;
      in_fire       = s_axis_tvalid & s_axis_tready;  // Stable until the edge
      out_fire_q    = m_axis_tvalid & m_axis_tready;
    end
    s_axis_tvalid = 1'b0;
  endtask

  task automatic check_stats(input opl_pkg::stats_t exp);
    exp_stats = exp;
    chk_stats = 1'b1;
    @(posedge axis_aclk);
    #1;
    chk_stats = 1'b0;
  endtask

  initial begin
    lcg_state      = 32'd65478;
    axis_resetn    = 1'b0;
    s_axis_tdata   = '0;
    s_axis_tkeep   = '0;
    s_axis_tuser   = '0;
    s_axis_tvalid  = 1'b0;
    s_axis_tlast   = 1'b0;
    m_axis_tready  = 1'b0;
    tgt_ip         = TGT_A;
    clear_counters = 1'b0;
    chk_stats      = 1'b0;
    exp_stats      = '0;
    exp_front      = '0;
    exp_pending    = 1'b0;
    exp_ready      = 1'b1;
    pkt_cnt        = 0;
    icmp_cnt       = 0;
    tgt_cnt        = 0;
    repeat (2) @(posedge axis_aclk);
    #1;
    axis_resetn = 1'b1;

    run_traffic(FIRST_PKTS);
    check_stats(traffic_stats('0));
    tgt_ip = TGT_B;  // Snapshot of tgt_out on the next edge
    @(posedge axis_aclk);
    #1;
    check_stats(traffic_stats(count_reg_value(tgt_cnt)));

    clear_counters = 1'b1;
    @(posedge axis_aclk);
    #1;
    clear_counters = 1'b0;
    pkt_cnt        = 0;
    icmp_cnt       = 0;
    tgt_cnt        = 0;
    check_stats('0);

    run_traffic(SECOND_PKTS);  // Past the 4 bit range
    check_stats(traffic_stats('0));

    $display("Test passed");
    $finish;
  end

  // Worst case 4 beats per packet and 20 cycles per beat
  initial begin
    repeat (TOTAL_PKTS * 4 * 20 + 200) @(posedge axis_aclk);
    stop_with_error("Timeout: the traffic did not drain in time");
  end

endmodule

// File: rtl/opl_top.sv
//##########################################################
// Output port lookup stage of the reference NIC
// COUNT_WIDTH must stay below CNT_MAX_WIDTH
// Latency is one edge through an empty input FIFO
//##########################################################
`timescale 1ns/1ps

module opl_top #(
  parameter int FIFO_DEPTH_BITS = 2,
  parameter int COUNT_WIDTH     = 31
) (
  input  logic                             axis_aclk,
  input  logic                             axis_resetn,
  // Slave stream from the RX queues
  input  logic [axis_pkg::DATA_WIDTH-1:0]  s_axis_tdata,
  input  logic [axis_pkg::KEEP_WIDTH-1:0]  s_axis_tkeep,
  input  logic [axis_pkg::TUSER_WIDTH-1:0] s_axis_tuser,
  input  logic                             s_axis_tvalid,
  output logic                             s_axis_tready,
  input  logic                             s_axis_tlast,
  // Master stream toward the datapath
  output logic [axis_pkg::DATA_WIDTH-1:0]  m_axis_tdata,
  output logic [axis_pkg::KEEP_WIDTH-1:0]  m_axis_tkeep,
  output logic [axis_pkg::TUSER_WIDTH-1:0] m_axis_tuser,
  output logic                             m_axis_tvalid,
  input  logic                             m_axis_tready,
  output logic                             m_axis_tlast,
  // Statistics side
  input  logic [31:0]                      tgt_ip,
  input  logic                             clear_counters,
  output opl_pkg::stats_t                  stats
);

  axis_pkg::beat_t     in_beat;
  axis_pkg::beat_t     head_beat;  // FIFO head
  opl_pkg::lookup_t    lookup;
  opl_pkg::pkt_event_t sel_events;
  opl_pkg::pkt_event_t pkt_events;
  logic                fifo_in_end;

  assign in_beat = '{tlast: s_axis_tlast, tuser: s_axis_tuser,
                     tkeep: s_axis_tkeep, tdata: s_axis_tdata};

  assign m_axis_tdata = head_beat.tdata;
  assign m_axis_tkeep = head_beat.tkeep;
  assign m_axis_tlast = head_beat.tlast;

  // Input side event joins the output side ones
  always_comb begin
    pkt_events        = sel_events;
    pkt_events.in_end = fifo_in_end;
  end

  stream_fifo #(.FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)) in_fifo (
    .axis_aclk, .axis_resetn,
    .in_beat  (in_beat),
    .in_valid (s_axis_tvalid),
    .in_ready (s_axis_tready),
    .out_beat (head_beat),
    .out_valid(m_axis_tvalid),
    .out_ready(m_axis_tready),
    .in_end   (fifo_in_end)
  );

  header_decode hdr_dec (.head(head_beat), .tgt_ip(tgt_ip), .lookup(lookup));

  port_select sel (
    .axis_aclk, .axis_resetn,
    .head         (head_beat),
    .head_valid   (m_axis_tvalid),
    .m_axis_tready(m_axis_tready),
    .lookup       (lookup),
    .m_axis_tuser (m_axis_tuser),
    .events       (sel_events)
  );

  stats_counters #(.COUNT_WIDTH(COUNT_WIDTH)) stats_cnt (
    .axis_aclk, .axis_resetn,
    .events        (pkt_events),
    .tgt_ip        (tgt_ip),
    .clear_counters(clear_counters),
    .stats         (stats)
  );

endmodule

// File: stats/stats_counters.sv
//##########################################################
// Packet statistics with sticky overflow flags
// Counts wrap at COUNT_WIDTH bits below the flag bit
// Clear wins over events in the same cycle
//##########################################################
`timescale 1ns/1ps

module stats_counters #(
  parameter int COUNT_WIDTH = 31
) (
  input  logic                axis_aclk,
  input  logic                axis_resetn,
  input  opl_pkg::pkt_event_t events,
  input  logic [31:0]         tgt_ip,
  input  logic                clear_counters,
  output opl_pkg::stats_t     stats
);

  localparam int TOP = opl_pkg::CNT_MAX_WIDTH - 1;  // Overflow flag bit

  logic [31:0] tgt_ip_q;  // Previous target address

  // One counter step with sticky overflow
  function automatic logic [opl_pkg::CNT_MAX_WIDTH-1:0] bump(
    input logic [opl_pkg::CNT_MAX_WIDTH-1:0] cur,
    input logic                              inc
  );
    logic [COUNT_WIDTH-1:0] cnt;
    logic                   ovf;
    cnt = cur[COUNT_WIDTH-1:0];
    ovf = cur[TOP];
    if (inc) begin
      ovf = ovf | (&cnt);  // Set on wrap
      cnt = cnt + 1'b1;
    end
    bump                  = '0;  // Unused middle bits read zero
    bump[TOP]             = ovf;
    bump[COUNT_WIDTH-1:0] = cnt;
  endfunction

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      stats    <= '0;
      tgt_ip_q <= '0;
    end else begin
      tgt_ip_q <= tgt_ip;
      if (clear_counters) begin
        stats <= '0;  // Flags too
      end else begin
        stats.pkt_in   <= bump(stats.pkt_in, events.in_end);
        stats.pkt_out  <= bump(stats.pkt_out, events.out_end);
        stats.icmp_out <= bump(stats.icmp_out, events.out_icmp);
        stats.tgt_out  <= bump(stats.tgt_out, events.out_tgt);
        // Snapshot the old target's count
        if (tgt_ip != tgt_ip_q) stats.tgt_out_last <= stats.tgt_out;
      end
    end
  end

  // Counts move by at most one outside a clear
  property p_step(logic [opl_pkg::CNT_MAX_WIDTH-1:0] r);
    @(posedge axis_aclk) disable iff (!axis_resetn)
      !clear_counters |=> COUNT_WIDTH'(r - $past(r)) <= COUNT_WIDTH'(1);
  endproperty

  a_step_pkt_in:   assert property (p_step(stats.pkt_in));
  a_step_pkt_out:  assert property (p_step(stats.pkt_out));
  a_step_icmp_out: assert property (p_step(stats.icmp_out));
  a_step_tgt_out:  assert property (p_step(stats.tgt_out));

  // Class pulses only ride on a packet start
  a_class_on_begin: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    (events.out_icmp || events.out_tgt) |-> events.out_begin)
    else $error("class event without packet start");

endmodule

// File: lookup/port_select.sv
//##########################################################
// Packet framing and tuser rewrite
// Only dst_port of the first beat is changed
// Event pulses are combinational from the FIFO head
//##########################################################
`timescale 1ns/1ps

module port_select (
  input  logic                axis_aclk,
  input  logic                axis_resetn,
  input  axis_pkg::beat_t     head,
  input  logic                head_valid,
  input  logic                m_axis_tready,
  input  opl_pkg::lookup_t    lookup,
  output axis_pkg::tuser_t    m_axis_tuser,
  output opl_pkg::pkt_event_t events
);

  localparam logic ST_HEADER = 1'b0;  // Waiting for a first beat
  localparam logic ST_IN_PKT = 1'b1;

  logic state;
  logic state_next;
  logic head_xfer;

  assign head_xfer = head_valid & m_axis_tready;

  // Rewrite on the first beat only
  always_comb begin
    m_axis_tuser = head.tuser;
    if (state == ST_HEADER) m_axis_tuser.dst_port = lookup.dst_port;
  end

  // Output side events
  always_comb begin
    events           = '0;                                 // in_end comes from the FIFO
    events.out_begin = head_valid & (state == ST_HEADER);  // Held while stalled
    events.out_end   = head_xfer & head.tlast;
    // Class pulses mark the accepted head beat so a packet counts once
    events.out_icmp  = events.out_begin & m_axis_tready & lookup.is_icmp;
    events.out_tgt   = events.out_begin & m_axis_tready & lookup.is_tgt;
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_HEADER: if (head_xfer && !head.tlast) state_next = ST_IN_PKT;  // Single beat stays
      ST_IN_PKT: if (head_xfer && head.tlast) state_next = ST_HEADER;
      default:   state_next = ST_HEADER;
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) state <= ST_HEADER;
    else              state <= state_next;
  end

  // FIFO must hold a stalled head beat
  a_head_stable: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    head_valid && !m_axis_tready |=> head_valid && $stable(head))
    else $error("head beat changed while stalled");

endmodule

// File: lookup/header_decode.sv
//##########################################################
// Head beat decode for port lookup and classification
// Purely combinational
// Valid only while the head beat is a packet's first beat
//##########################################################
`timescale 1ns/1ps

module header_decode (
  input  axis_pkg::beat_t  head,
  input  logic [31:0]      tgt_ip,
  output opl_pkg::lookup_t lookup
);

  localparam axis_pkg::port_t DMA_MASK = 8'hAA;  // Odd port bits
  localparam axis_pkg::port_t MAC0     = 8'h01;

  opl_pkg::head_beat_u view;
  axis_pkg::port_t     src;
  logic                from_cpu;

  always_comb begin
    view.raw = head.tdata;          // Read back through the header view
    src      = head.tuser.src_port;
    from_cpu = |(src & DMA_MASK);

    // Egress port rule
    if (src == '0) begin
      lookup.dst_port = MAC0;       // No source so default MAC 0
    end else if (from_cpu) begin
      lookup.dst_port = src >> 1;   // DMA n to MAC n
    end else begin
      lookup.dst_port = src << 1;   // MAC n to DMA n
    end

    // Classification for the counters
    lookup.is_icmp = (view.hdr.protocol == opl_pkg::ICMP_PROTO);
    lookup.is_tgt  = (view.hdr.ip_dst == tgt_ip);
  end

endmodule

// File: rtl/stream_fifo.sv
//##########################################################
// Fall-through FIFO holding whole stream beats
// Ready drops at depth minus one entries
// Head entry is readable without a read cycle
//##########################################################
`timescale 1ns/1ps

module stream_fifo #(
  parameter int FIFO_DEPTH_BITS = 2
) (
  input  logic            axis_aclk,
  input  logic            axis_resetn,
  input  axis_pkg::beat_t in_beat,
  input  logic            in_valid,
  output logic            in_ready,
  output axis_pkg::beat_t out_beat,
  output logic            out_valid,
  input  logic            out_ready,
  output logic            in_end     // tlast accepted
);

  localparam int DEPTH = 1 << FIFO_DEPTH_BITS;
  localparam int CW    = FIFO_DEPTH_BITS + 1;  // Count width

  axis_pkg::beat_t            mem [DEPTH];
  logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic [CW-1:0]              count;    // Occupancy
  logic                       nearly_full;
  logic                       wr_en;
  logic                       rd_en;

  assign nearly_full = (count >= CW'(DEPTH - 1));
  assign in_ready    = ~nearly_full;
  assign wr_en       = in_valid & ~nearly_full;
  assign out_valid   = (count != '0);
  assign rd_en       = out_ready & out_valid;
  assign in_end      = wr_en & in_beat.tlast;

  assign out_beat = mem[rd_ptr];  // Fall-through head

  // Storage
  always_ff @(posedge axis_aclk) begin
    if (wr_en) mem[wr_ptr] <= in_beat;
  end

  // Pointers and occupancy
  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Both or none
      endcase
    end
  end

  // Guard the buffer against overrun and underrun
  // Equal pointers with a nonzero count mean every slot is taken
  a_no_write_full: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    wr_en |-> (count == '0) || (wr_ptr != rd_ptr))
    else $error("write into a full FIFO");

  a_no_pop_empty: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    rd_en |-> wr_ptr != rd_ptr)
    else $error("pop from an empty FIFO");

endmodule

// File: common/opl_pkg.sv
//##########################################################
// Lookup, event and statistics types
// Header offsets assume IPv4 without options
// Counter registers carry the overflow flag in the top bit
//##########################################################
package opl_pkg;

  localparam logic [7:0] ICMP_PROTO = 8'd1;  // IPv4 protocol number

  // Widest counter register
  localparam int CNT_MAX_WIDTH = 32;

  // Head beat as seen by the decoder
  typedef struct packed {
    logic [axis_pkg::DATA_WIDTH-273:0] pad_hi;   // L4 header and payload
    logic [31:0]                       ip_dst;   // Offset 240
    logic [31:0]                       ip_src;   // Offset 208
    logic [15:0]                       hdr_csum;
    logic [7:0]                        protocol; // Offset 184
    logic [183:0]                      pad_lo;   // MAC header and first IP words
  } ipv4_hdr_t;

  // First beat decoded as header and later beats kept raw
  typedef union packed {
    logic [axis_pkg::DATA_WIDTH-1:0] raw;
    ipv4_hdr_t                       hdr;
  } head_beat_u;

  // Result of the header lookup
  typedef struct packed {
    axis_pkg::port_t dst_port;
    logic            is_icmp;
    logic            is_tgt;   // Destination IP hits target
  } lookup_t;

  // Single-cycle packet event pulses
  typedef struct packed {
    logic in_end;    // tlast accepted at the input
    logic out_begin; // Head beat waiting at the output
    logic out_end;   // tlast sent at the output
    logic out_icmp;  // ICMP head beat sent
    logic out_tgt;   // Target head beat sent
  } pkt_event_t;

  // Statistics registers
  // Overflow flag in the top bit and count in the low bits
  typedef struct packed {
    logic [CNT_MAX_WIDTH-1:0] pkt_in;
    logic [CNT_MAX_WIDTH-1:0] pkt_out;
    logic [CNT_MAX_WIDTH-1:0] icmp_out;
    logic [CNT_MAX_WIDTH-1:0] tgt_out;
    logic [CNT_MAX_WIDTH-1:0] tgt_out_last;  // Snapshot on target change
  } stats_t;

endpackage

// File: common/axis_pkg.sv
//##########################################################
// AXI-Stream widths and beat types for the lookup stage
// tuser holds one-hot source and destination ports
// Destination field must sit directly above the source field
//##########################################################
package axis_pkg;

  localparam int DATA_WIDTH  = 512;
  localparam int KEEP_WIDTH  = DATA_WIDTH / 8;  // One bit per byte
  localparam int TUSER_WIDTH = 128;

  localparam int SRC_PORT_POS = 16;  // Ingress port field
  localparam int DST_PORT_POS = 24;  // Egress port field

  // One-hot port vector
  // Even bits are MAC ports and odd bits DMA ports
  typedef logic [7:0] port_t;

  typedef struct packed {
    logic [TUSER_WIDTH-DST_PORT_POS-9:0] rsvd;     // Passed through untouched
    port_t                               dst_port; // Rewritten on head beat
    port_t                               src_port;
    logic [SRC_PORT_POS-1:0]             pkt_len;  // Bytes
  } tuser_t;

  // Whole beat as stored in the input FIFO
  typedef struct packed {
    logic                  tlast;
    tuser_t                tuser;
    logic [KEEP_WIDTH-1:0] tkeep;
    logic [DATA_WIDTH-1:0] tdata;
  } beat_t;

endpackage
